/* run.sh */
#!/usr/bin/env bash
# build and run the pci target testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbPciTarget -o simPciTarget
./obj_dir/simPciTarget | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

/* src/pciCfgIf.sv */
//////////////////////////////
// link between transaction control and config header
//////////////////////////////
`timescale 1ns/1ps
`include "pci_settings.svh"

interface pciCfgIf import pciPkg::*;;

  // from transaction control
  logic   cfgWrite;  // one config data-phase write
  regIdx  idx;       // current dword index
  pciWord wrData;    // AD during the data phase

  // decode values back from the header
  logic                      ioEnable;
  logic                      memEnable;
  logic [`PCI_BAR0_BITS-1:0] bar0;
  logic [`PCI_BAR1_BITS-1:0] bar1;
  pciWord                    csRead;  // config word at idx

  modport ctrl (
    output cfgWrite, idx, wrData,
    input  ioEnable, memEnable, bar0, bar1, csRead
  );

  modport cfg (
    input  cfgWrite, idx, wrData,
    output ioEnable, memEnable, bar0, bar1, csRead
  );

endinterface

/* src/pciConfigSpace.sv */
//////////////////////////////
// type 0 configuration header
// enables, BARs, interrupt line and read word
//////////////////////////////
`timescale 1ns/1ps
`include "pci_settings.svh"

module pciConfigSpace import pciPkg::*; (
  input  logic PCI_CLK,
  input  logic PCI_RSTn,
  pciCfgIf.cfg cfg
);

  logic                      ioEn;     // command bit 0
  logic                      memEn;    // command bit 1
  logic [`PCI_BAR0_BITS-1:0] bar0Reg;  // io base, AD[15:6]
  logic [`PCI_BAR1_BITS-1:0] bar1Reg;  // mem base, AD[31:16]
  logic [7:0]                intLine;  // written by the BIOS, unused here
  logic                      wrCmd, wrBar0, wrBar1, wrIntLine;
  pciWord                    csWord;

  //////////////////////////////
  // header writes
  //////////////////////////////
  assign wrCmd     = cfg.cfgWrite & (cfg.idx == `CFG_IDX_CMD);
  assign wrBar0    = cfg.cfgWrite & (cfg.idx == `CFG_IDX_BAR0);
  assign wrBar1    = cfg.cfgWrite & (cfg.idx == `CFG_IDX_BAR1);
  assign wrIntLine = cfg.cfgWrite & (cfg.idx == `CFG_IDX_INTLINE);

  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      ioEn    <= 1'b0;
      memEn   <= 1'b0;
      bar0Reg <= '0;
      bar1Reg <= '0;
      intLine <= 8'h00;
    end else begin
      if (wrCmd) begin
        ioEn  <= cfg.wrData[0];
        memEn <= cfg.wrData[1];
      end
      if (wrBar0)    bar0Reg <= cfg.wrData[6 +: `PCI_BAR0_BITS];   // 64 byte window
      if (wrBar1)    bar1Reg <= cfg.wrData[31 -: `PCI_BAR1_BITS];  // 64 KB window
      if (wrIntLine) intLine <= cfg.wrData[7:0];
    end
  end

  assign cfg.ioEnable  = ioEn;
  assign cfg.memEnable = memEn;
  assign cfg.bar0      = bar0Reg;
  assign cfg.bar1      = bar1Reg;

  //////////////////////////////
  // header read word
  //////////////////////////////
  always_comb begin
    csWord = '0;  // unimplemented dwords read zero
    case (cfg.idx)
      `CFG_IDX_ID: csWord = {`PCI_DEVICE_ID, `PCI_VENDOR_ID};
      `CFG_IDX_CMD: begin
        // status half stays zero, devsel timing fast
        csWord[1:0] = {memEn, ioEn};
      end
      `CFG_IDX_CLASS: csWord = `PCI_CLASS_CODE;  // class code, rev 0
      `CFG_IDX_BAR0: begin
        csWord[6 +: `PCI_BAR0_BITS] = bar0Reg;
        csWord[0]                   = 1'b1;      // io space indicator
      end
      `CFG_IDX_BAR1: begin
        csWord[31 -: `PCI_BAR1_BITS] = bar1Reg;  // 32-bit, non-prefetchable
      end
      `CFG_IDX_INTLINE: csWord[15:0] = {`PCI_INT_PIN, intLine};  // min_gnt/max_lat 0
      default: ;
    endcase
  end

  assign cfg.csRead = csWord;

endmodule

/* src/pciPkg.sv */
//////////////////////////////
// pci target types
// data word, register index, bus space and command codes
//////////////////////////////
package pciPkg;

  typedef logic [31:0] pciWord;  // one AD word
  typedef logic [3:0]  regIdx;   // dword index inside a space

  // space a transaction was decoded into
  typedef enum logic [1:0] {
    spNone = 2'd0,
    spIo   = 2'd1,
    spMem  = 2'd2,
    spConf = 2'd3
  } busSpace;

  // C/BE# during the address phase
  typedef enum logic [3:0] {
    cmdIoRead      = 4'b0010,
    cmdIoWrite     = 4'b0011,
    cmdMemRead     = 4'b0110,
    cmdMemWrite    = 4'b0111,
    cmdCfgRead     = 4'b1010,
    cmdCfgWrite    = 4'b1011,
    cmdMemReadMult = 4'b1100,
    cmdMemReadLine = 4'b1110,
    cmdMemWriteInv = 4'b1111
  } pciCmd;

endpackage

/* src/pciTarget.sv */
//////////////////////////////
// 32-bit zero wait state pci target, top level
//////////////////////////////
`timescale 1ns/1ps

module pciTarget import pciPkg::*; (
  input  logic       PCI_CLK,
  input  logic       PCI_RSTn,
  input  logic       frameN,
  input  logic       irdyN,
  input  logic       idsel,
  input  logic [3:0] cbeN,
  input  pciWord     adIn,
  input  pciWord     switches,
  output pciWord     adOut,
  output logic       adOe,
  output logic       devselN,
  output logic       trdyN,
  output logic       targetOe,
  output logic       intaN,
  output logic [1:0] led
);

  pciWord  userRead;   // register word back to the AD mux
  pciWord  wrData;
  logic    ioWrite, memWrite;
  regIdx   regIndex;
  busSpace space;

  pciCfgIf cfgBus ();  // ctrl <-> header

  pciTargetCtrl ctrl (
    .PCI_CLK  (PCI_CLK),
    .PCI_RSTn (PCI_RSTn),
    .frameN   (frameN),
    .irdyN    (irdyN),
    .idsel    (idsel),
    .cbeN     (cbeN),
    .adIn     (adIn),
    .userRead (userRead),
    .devselN  (devselN),
    .trdyN    (trdyN),
    .targetOe (targetOe),
    .adOe     (adOe),
    .adOut    (adOut),
    .ioWrite  (ioWrite),
    .memWrite (memWrite),
    .space    (space),
    .regIndex (regIndex),
    .wrData   (wrData),
    .cfg      (cfgBus.ctrl)
  );

  pciConfigSpace cfgSpace (
    .PCI_CLK  (PCI_CLK),
    .PCI_RSTn (PCI_RSTn),
    .cfg      (cfgBus.cfg)
  );

  pciUserRegs userRegs (
    .PCI_CLK  (PCI_CLK),
    .PCI_RSTn (PCI_RSTn),
    .ioWrite  (ioWrite),
    .memWrite (memWrite),
    .regIndex (regIndex),
    .wrData   (wrData),
    .switches (switches),
    .space    (space),
    .userRead (userRead),
    .intaN    (intaN),
    .led      (led)
  );

endmodule

/* src/pciTargetCtrl.sv */
//////////////////////////////
// pci target transaction control
// tracks frames, decodes and claims cycles, drives devsel/trdy/ad
//////////////////////////////
`timescale 1ns/1ps
`include "pci_settings.svh"

module pciTargetCtrl import pciPkg::*; (
  input  logic       PCI_CLK,
  input  logic       PCI_RSTn,
  input  logic       frameN,
  input  logic       irdyN,
  input  logic       idsel,
  input  logic [3:0] cbeN,
  input  pciWord     adIn,
  input  pciWord     userRead,  // io/mem register word at regIndex
  output logic       devselN,
  output logic       trdyN,
  output logic       targetOe,  // enable for DEVSEL# and TRDY#
  output logic       adOe,
  output pciWord     adOut,
  output logic       ioWrite,
  output logic       memWrite,
  output busSpace    space,     // latched space of the current cycle
  output regIdx      regIndex,
  output pciWord     wrData,
  pciCfgIf.ctrl      cfg
);

  logic    transaction;   // frame seen, bus not yet idle
  logic    wasLastXfer;   // final data phase on the previous edge
  logic    start, idle, transEnd;
  logic    dataXfer, lastXfer;
  pciCmd   cmd;
  busSpace cmdSpace;      // space of the command on the bus now
  logic    hit;
  logic    readNWrite;
  logic    devSel, targetReady, devSelOe, adOeReg;
  regIdx   idx;

  //////////////////////////////
  // bus phase tracking
  //////////////////////////////
  assign dataXfer = ~irdyN & targetReady;  // only our own ready counts
  assign lastXfer = dataXfer & frameN;
  assign idle     = frameN & irdyN;
  assign transEnd = transaction & idle;
  // initial start, or fast back-to-back right after a final phase
  assign start    = ~frameN & (~transaction | wasLastXfer);

  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      transaction <= 1'b0;
      wasLastXfer <= 1'b0;
    end else begin
      if (!transaction) transaction <= start;
      else              transaction <= ~transEnd;
      wasLastXfer <= lastXfer;
    end
  end

  //////////////////////////////
  // address phase decode
  //////////////////////////////
  assign cmd = pciCmd'(cbeN);

  always_comb begin
    case (cmd)
      cmdIoRead, cmdIoWrite:               cmdSpace = spIo;
      cmdMemRead, cmdMemWrite, cmdMemReadMult,
      cmdMemReadLine, cmdMemWriteInv:      cmdSpace = spMem;
      cmdCfgRead, cmdCfgWrite:             cmdSpace = spConf;
      default:                             cmdSpace = spNone;  // special, dual addr etc
    endcase
  end

  always_comb begin
    case (cmdSpace)
      spIo:    hit = cfg.ioEnable & (adIn[6 +: `PCI_BAR0_BITS] == cfg.bar0)
                     & (adIn[1:0] == 2'b00);
      spMem:   hit = cfg.memEnable & (adIn[31 -: `PCI_BAR1_BITS] == cfg.bar1);
      spConf:  hit = idsel & (adIn[1:0] == 2'b00);  // type 0 only
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      readNWrite <= 1'b0;
      space      <= spNone;
    end else if (start) begin
      readNWrite <= ~cbeN[0];  // even codes are reads
      space      <= cmdSpace;
    end
  end

  // dword index, auto-increment per transfer
  always_ff @(posedge PCI_CLK) begin
    if (start)         idx <= adIn[5:2];
    else if (dataXfer) idx <= idx + 4'd1;
  end

  //////////////////////////////
  // claim, ready, turnaround
  //////////////////////////////
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      devSel      <= 1'b0;
      targetReady <= 1'b0;
      devSelOe    <= 1'b0;
      adOeReg     <= 1'b0;
    end else begin
      if (start) begin
        devSel      <= hit;
        targetReady <= hit & cbeN[0];  // writes ready at once
        devSelOe    <= hit;
      end else begin
        devSel      <= devSel & ~lastXfer;
        targetReady <= devSel & ~lastXfer;  // reads one cycle later
        if (transEnd) devSelOe <= 1'b0;     // hold until bus idle
      end
      adOeReg <= devSel & readNWrite & ~lastXfer;  // after turnaround
    end
  end

  assign devselN  = ~devSel;
  assign trdyN    = ~targetReady;
  assign targetOe = devSelOe;
  assign adOe     = adOeReg;

  //////////////////////////////
  // data path
  //////////////////////////////
  assign ioWrite      = dataXfer & ~readNWrite & (space == spIo);
  assign memWrite     = dataXfer & ~readNWrite & (space == spMem);
  assign cfg.cfgWrite = dataXfer & ~readNWrite & (space == spConf);

  assign regIndex   = idx;
  assign cfg.idx    = idx;
  assign wrData     = adIn;
  assign cfg.wrData = adIn;

  // user regs for io/mem, header otherwise
  assign adOut = (space == spIo || space == spMem) ? userRead : cfg.csRead;

endmodule

/* src/pciUserRegs.sv */
//////////////////////////////
// io/mem register file and interrupt timer
//////////////////////////////
`timescale 1ns/1ps
`include "pci_settings.svh"

module pciUserRegs import pciPkg::*; (
  input  logic       PCI_CLK,
  input  logic       PCI_RSTn,
  input  logic       ioWrite,
  input  logic       memWrite,
  input  regIdx      regIndex,
  input  pciWord     wrData,
  input  pciWord     switches,
  input  busSpace    space,
  output pciWord     userRead,
  output logic       intaN,
  output logic [1:0] led
);

  logic [2:0]                     ledReg;
  pciWord                         statusReg;   // scratch, read/write
  logic [`PCI_INT_TIMER_BITS-1:0] intTimer;
  logic                           intPulse;

  //////////////////////////////
  // register writes
  //////////////////////////////
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      ledReg <= 3'b000;
    end else if (regIndex == `USR_IDX_LED) begin
      if (ioWrite)       ledReg <= wrData[5:3];  // io view sits at bits 5:3
      else if (memWrite) ledReg <= wrData[2:0];
    end
  end

  always_ff @(posedge PCI_CLK) begin
    if (ioWrite || memWrite) begin
      if (regIndex == `USR_IDX_STATUS) statusReg <= wrData;
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////
  always_comb begin
    userRead = '0;
    if (space == spIo || space == spMem) begin
      case (regIndex)
        `USR_IDX_ID:     userRead = (space == spIo) ? `PCI_IO_ID_WORD : `PCI_MEM_ID_WORD;
        `USR_IDX_LED:    userRead = (space == spIo) ? {26'd0, ledReg, 3'b000}
                                                    : {29'd0, ledReg};
        `USR_IDX_STATUS: userRead = statusReg;
        `USR_IDX_SWITCH: userRead = switches;  // read only
        default: ;                             // wrdata and the rest read zero
      endcase
    end
  end

  // free-running timer, one-cycle pulse on wrap
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      intTimer <= '0;
      intPulse <= 1'b0;
    end else begin
      intTimer <= intTimer + 1'b1;
      intPulse <= &intTimer;
    end
  end

  assign intaN = ~intPulse;
  assign led   = {intaN, ledReg[0]};  // led1 follows INTA#

endmodule

/* src/pci_settings.svh */
//////////////////////////////
// pci target settings
// header constants, BAR compare widths, timer width, register indices
//////////////////////////////
`ifndef PCI_SETTINGS_SVH
`define PCI_SETTINGS_SVH

`define PCI_VENDOR_ID      16'h0100
`define PCI_DEVICE_ID      16'h0001
`define PCI_CLASS_CODE     32'h0880_0000  // base system peripheral, other
`define PCI_INT_PIN        8'h01          // INTA#

`define PCI_BAR0_BITS      10  // io compare field, AD[15:6]
`define PCI_BAR1_BITS      16  // mem compare field, AD[31:16]

`define PCI_INT_TIMER_BITS 6   // 64 cycle irq period

`define PCI_IO_ID_WORD     32'h0000_4F49  // "IO"
`define PCI_MEM_ID_WORD    32'h004D_454D  // "MEM"

// config header double-word indices
`define CFG_IDX_ID         4'h0
`define CFG_IDX_CMD        4'h1
`define CFG_IDX_CLASS      4'h2
`define CFG_IDX_BAR0       4'h4
`define CFG_IDX_BAR1       4'h5
`define CFG_IDX_INTLINE    4'hF

// user register indices, same in io and mem space
`define USR_IDX_ID         4'h0
`define USR_IDX_LED        4'h1
`define USR_IDX_STATUS     4'h2
`define USR_IDX_SWITCH     4'h3
`define USR_IDX_WRDATA     4'h4

`endif

/* tb.f */
+incdir+src
src/pciPkg.sv
src/pciCfgIf.sv
src/pciTargetCtrl.sv
src/pciConfigSpace.sv
src/pciUserRegs.sv
src/pciTarget.sv
test/pciTarget_props.sv
test/tbPciTarget.sv

/* test/pciTarget_props.sv */
//////////////////////////////
// pci target protocol assertions
//////////////////////////////
`timescale 1ns/1ps

module pciTargetProps (
  input logic       PCI_CLK,
  input logic       PCI_RSTn,
  input logic [3:0] cbeN,
  input logic       devselN,
  input logic       trdyN,
  input logic       adOe,
  input logic       intaN
);

  logic [3:0] cbeQ;     // C/BE# one edge back
  logic       devselQ;  // DEVSEL# one edge back
  logic       wrCycle;  // claimed cycle carries a write command

  // command of the claimed cycle, taken where DEVSEL# falls
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      cbeQ    <= 4'hF;
      devselQ <= 1'b1;
      wrCycle <= 1'b0;
    end else begin
      cbeQ    <= cbeN;
      devselQ <= devselN;
      if (devselQ && !devselN) wrCycle <= cbeQ[0];  // odd codes write
    end
  end

  // no ready without a claim
  trdyNeedsDevsel: assert property (
    @(posedge PCI_CLK) disable iff (!PCI_RSTn) !trdyN |-> !devselN
  ) else $error("TRDY# low while DEVSEL# high");

  // AD driven on reads only
  adOeOnReads: assert property (
    @(posedge PCI_CLK) disable iff (!PCI_RSTn) adOe |-> !wrCycle
  ) else $error("AD output enabled during a write");

  // irq is a single cycle pulse
  intaSingleCycle: assert property (
    @(posedge PCI_CLK) disable iff (!PCI_RSTn) $fell(intaN) |=> intaN
  ) else $error("INTA# low for more than one cycle");

endmodule

bind pciTarget pciTargetProps props (
  .PCI_CLK  (PCI_CLK),
  .PCI_RSTn (PCI_RSTn),
  .cbeN     (cbeN),
  .devselN  (devselN),
  .trdyN    (trdyN),
  .adOe     (adOe),
  .intaN    (intaN)
);

/* test/tbPciTarget.sv */
//////////////////////////////
// pci target testbench
// random config, io and mem cycles against a reference model
//////////////////////////////
`timescale 1ns/1ps
`include "pci_settings.svh"

module tbPciTarget import pciPkg::*; ();

  localparam int NUM_BURSTS   = 40;
  localparam int NUM_B2B      = 6;
  localparam int BURST_CYCLES = 20;  // addr, 4 phases with 3 waits, turnaround, idle
  localparam int BUS_CYCLES   = 32 * 8 + (NUM_BURSTS + 1 + 2 * NUM_B2B) * BURST_CYCLES;
  localparam int TIMEOUT      = 2 * BUS_CYCLES + 200;
  localparam int INT_PERIOD   = 1 << `PCI_INT_TIMER_BITS;

  logic       PCI_CLK = 1'b0;
  logic       PCI_RSTn, frameN, irdyN, idsel;
  logic [3:0] cbeN;
  pciWord     adIn, switches, adOut;
  logic       adOe, devselN, trdyN, targetOe, intaN;
  logic [1:0] led;

  // reference model of header and registers
  logic       mIoEn, mMemEn;
  logic [9:0] mBar0;
  logic [15:0] mBar1;
  logic [7:0] mIntLine;
  logic [2:0] mLed;
  pciWord     mStatus;

  logic [31:0] lfsr = 32'hc27f_5473;
  pciWord      wrBuf [4];            // write data for one burst
  int          errors = 0;
  int          checks = 0;
  int          cycleCount = 0;
  int          edgesSinceRst = 0;
  regIdx       hdrIdx [6] = '{`CFG_IDX_ID, `CFG_IDX_CMD, `CFG_IDX_CLASS,
                              `CFG_IDX_BAR0, `CFG_IDX_BAR1, `CFG_IDX_INTLINE};

  pciTarget dut (.*);

  always #20 PCI_CLK = ~PCI_CLK;  // 25 MHz

  //////////////////////////////
  // helpers
  //////////////////////////////
  // fibonacci lfsr, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic pciWord cfgAddr(input regIdx idx);
    return {26'd0, idx, 2'b00};  // type 0, register number in 7:2
  endfunction

  function automatic logic [3:0] cmdFor(input busSpace sp, input logic rd);
    case (sp)
      spIo:    return rd ? cmdIoRead : cmdIoWrite;
      spMem:   return rd ? cmdMemRead : cmdMemWrite;
      default: return rd ? cmdCfgRead : cmdCfgWrite;
    endcase
  endfunction

  function automatic logic expectHit(input busSpace sp, input pciWord a, input logic sel);
    case (sp)
      spIo:    return mIoEn && a[15:6] == mBar0 && a[1:0] == 2'b00;
      spMem:   return mMemEn && a[31:16] == mBar1;
      default: return sel && a[1:0] == 2'b00;
    endcase
  endfunction

  // expected word for a read at idx
  function automatic pciWord expectRead(input busSpace sp, input regIdx idx);
    pciWord w;
    w = '0;
    if (sp == spConf) begin
      case (idx)
        `CFG_IDX_ID:      w = {`PCI_DEVICE_ID, `PCI_VENDOR_ID};
        `CFG_IDX_CMD:     w = {30'd0, mMemEn, mIoEn};  // status half zero
        `CFG_IDX_CLASS:   w = `PCI_CLASS_CODE;
        `CFG_IDX_BAR0:    w = {16'd0, mBar0, 6'b000001};
        `CFG_IDX_BAR1:    w = {mBar1, 16'd0};
        `CFG_IDX_INTLINE: w = {16'd0, `PCI_INT_PIN, mIntLine};
        default: ;
      endcase
    end else begin
      case (idx)
        `USR_IDX_ID:     w = (sp == spIo) ? `PCI_IO_ID_WORD : `PCI_MEM_ID_WORD;
        `USR_IDX_LED:    w = (sp == spIo) ? {26'd0, mLed, 3'd0} : {29'd0, mLed};
        `USR_IDX_STATUS: w = mStatus;
        `USR_IDX_SWITCH: w = switches;
        default: ;  // write data word and the rest
      endcase
    end
    return w;
  endfunction

  task automatic modelWrite(input busSpace sp, input regIdx idx, input pciWord d);
    if (sp == spConf) begin
      if (idx == `CFG_IDX_CMD)     {mMemEn, mIoEn} = d[1:0];
      if (idx == `CFG_IDX_BAR0)    mBar0 = d[15:6];
      if (idx == `CFG_IDX_BAR1)    mBar1 = d[31:16];
      if (idx == `CFG_IDX_INTLINE) mIntLine = d[7:0];
    end else begin
      if (idx == `USR_IDX_LED)    mLed = (sp == spIo) ? d[5:3] : d[2:0];
      if (idx == `USR_IDX_STATUS) mStatus = d;
    end
  endtask

  task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic tick();
    @(posedge PCI_CLK);
    #2;  // drive point
  endtask

  // claim state in cycle k after the address edge
  task automatic claimCheck(input logic hit, input logic rd, input int k);
    checkVal("devselN", !hit, devselN);
    checkVal("targetOe", hit, targetOe);
    checkVal("trdyN", !(hit && (!rd || k > 0)), trdyN);
    checkVal("adOe", hit && rd && k > 0, adOe);
  endtask

  task automatic releasedCheck(input logic oe);
    checkVal("devselN", 1, devselN);
    checkVal("trdyN", 1, trdyN);
    checkVal("adOe", 0, adOe);
    checkVal("targetOe", oe, targetOe);
  endtask

  //////////////////////////////
  // bus initiator
  //////////////////////////////
  // one transaction, returns in the cycle after the final transfer
  task automatic busXfer(input busSpace sp, input logic rd, input pciWord addr,
                         input logic sel, input int n);
    logic  hit;
    int    k;
    int    waits;
    regIdx idx;
    hit    = expectHit(sp, addr, sel);
    idx    = addr[5:2];
    frameN = 1'b0;
    irdyN  = 1'b1;
    cbeN   = cmdFor(sp, rd);
    adIn   = addr;
    idsel  = sel;
    tick();
    k = 0;
    claimCheck(hit, rd, k);
    cbeN = 4'h0;  // all bytes enabled
    if (!hit) begin
      frameN = 1'b1;  // master abort, nobody claims
      irdyN  = 1'b0;
      repeat (4) begin
        tick();
        claimCheck(1'b0, rd, 1);
      end
    end else begin
      for (int i = 0; i < n; i++) begin
        waits = int'(randBits(2));
        irdyN = 1'b1;
        repeat (waits) begin
          tick();
          k++;
          claimCheck(1'b1, rd, k);
        end
        irdyN  = 1'b0;
        frameN = (i == n - 1);  // last phase
        adIn   = rd ? 32'h0 : wrBuf[i];
        while (trdyN) begin
          tick();
          k++;
          claimCheck(1'b1, rd, k);
        end
        if (rd) checkVal("adOut", expectRead(sp, idx), adOut);
        tick();  // transfer edge
        k++;
        if (!rd) modelWrite(sp, idx, wrBuf[i]);
        idx++;
        if (i < n - 1) claimCheck(1'b1, rd, k);
      end
      releasedCheck(1'b1);  // oe held until idle
    end
  endtask

  task automatic endBus();
    frameN = 1'b1;
    irdyN  = 1'b1;
    cbeN   = 4'hF;
    idsel  = 1'b0;
    tick();
    releasedCheck(1'b0);
  endtask

  task automatic single(input busSpace sp, input logic rd, input pciWord addr,
                        input logic sel, input pciWord d);
    wrBuf[0] = d;
    busXfer(sp, rd, addr, sel, 1);
    endBus();
  endtask

  //////////////////////////////
  // monitors
  //////////////////////////////
  always @(posedge PCI_CLK) begin
    cycleCount <= cycleCount + 1;
    if (PCI_RSTn) edgesSinceRst <= edgesSinceRst + 1;
    if (cycleCount == TIMEOUT) begin
      $display("timeout: bus sequence not finished after %0d cycles", TIMEOUT);
      $display("checks %0d, errors %0d", checks, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // irq pulse once per timer wrap, led follows
  always @(negedge PCI_CLK) begin
    if (PCI_RSTn) begin
      checkVal("intaN", !(edgesSinceRst != 0 && edgesSinceRst % INT_PERIOD == 0), intaN);
      checkVal("led[1]", !(edgesSinceRst != 0 && edgesSinceRst % INT_PERIOD == 0), led[1]);
      checkVal("led[0]", mLed[0], led[0]);
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    busSpace sp;
    logic    rd;
    int      n;
    pciWord  ioBase, memBase;
    PCI_RSTn = 1'b0;
    frameN   = 1'b1;
    irdyN    = 1'b1;
    idsel    = 1'b0;
    cbeN     = 4'hF;
    adIn     = '0;
    switches = '0;
    {mIoEn, mMemEn, mBar0, mBar1, mIntLine, mLed, mStatus} = '0;
    repeat (5) @(posedge PCI_CLK);
    #2;
    releasedCheck(1'b0);  // still in reset
    checkVal("intaN", 1, intaN);
    PCI_RSTn = 1'b1;
    switches = randBits(32);

    foreach (hdrIdx[i]) single(spConf, 1'b1, cfgAddr(hdrIdx[i]), 1'b1, '0);
    single(spIo, 1'b1, 32'h0, 1'b0, '0);    // enables still off
    single(spMem, 1'b0, 32'h0, 1'b0, randBits(32));

    // random header writes, read back through masks
    repeat (2) begin
      for (int i = 1; i < 6; i++) begin
        if (hdrIdx[i] != `CFG_IDX_CLASS) begin
          single(spConf, 1'b0, cfgAddr(hdrIdx[i]), 1'b1, randBits(32));
          single(spConf, 1'b1, cfgAddr(hdrIdx[i]), 1'b1, '0);
        end
      end
    end

    single(spConf, 1'b0, cfgAddr(`CFG_IDX_CMD), 1'b1, 32'h3);
    single(spConf, 1'b0, cfgAddr(`CFG_IDX_BAR0), 1'b1, {16'd0, 10'(randBits(10)), 6'd0});
    single(spConf, 1'b0, cfgAddr(`CFG_IDX_BAR1), 1'b1, {16'(randBits(16)), 16'd0});
    ioBase  = {16'd0, mBar0, 6'd0};
    memBase = {mBar1, 16'd0};
    single(spIo, 1'b1, ioBase ^ 32'h40, 1'b0, '0);          // outside both windows
    single(spMem, 1'b1, memBase ^ 32'h0001_0000, 1'b0, '0);
    single(spConf, 1'b1, cfgAddr(`CFG_IDX_ID), 1'b0, '0);   // idsel low

    // bursts with wait states
    single(spMem, 1'b0, memBase | 32'h8, 1'b0, randBits(32));  // status known
    for (int b = 0; b < NUM_BURSTS; b++) begin
      sp = (randBits(1) != 0) ? spMem : spIo;
      rd = randBits(1) != 0;
      n  = int'(randBits(2)) + 1;
      foreach (wrBuf[i]) wrBuf[i] = randBits(32);
      if (b % 8 == 7) switches = randBits(32);
      busXfer(sp, rd, ((sp == spIo) ? ioBase : memBase) | {27'd0, 3'(randBits(3)), 2'b00},
              1'b0, n);
      endBus();
    end

    // fast back-to-back, write then read of the same words
    for (int j = 0; j < NUM_B2B; j++) begin
      sp = (randBits(1) != 0) ? spMem : spIo;
      n  = int'(randBits(2)) + 1;
      ioBase[5:2]  = {1'b0, 3'(randBits(3))};
      memBase[5:2] = ioBase[5:2];
      foreach (wrBuf[i]) wrBuf[i] = randBits(32);
      busXfer(sp, 1'b0, (sp == spIo) ? ioBase : memBase, 1'b0, n);
      busXfer(sp, 1'b1, (sp == spIo) ? ioBase : memBase, 1'b0, n);
      endBus();
    end

    repeat (4) tick();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
